/* hw/mc_collect.sv */
// reply collector: merges tile reply lanes, tags the tile and counts replies
`timescale 1ns/10ps

module mc_collect (
  input  logic                                      clk,
  input  logic                                      reset,

  // reply lanes, one per tile
  input  logic [mc_pkg::num_tiles-1:0]              rep_v_i,
  input  mc_pkg::data_t [mc_pkg::num_tiles-1:0]     rep_data_i,

  // merged reply
  output logic                                      resp_v_o,
  output mc_pkg::tile_id_t                          resp_tile_o,
  output mc_pkg::data_t                             resp_data_o,
  output mc_pkg::count_t                            resp_count_o
);

  logic             any_v;
  mc_pkg::tile_id_t sel;

  // only one command per cycle, so lanes never overlap
  assign any_v = |rep_v_i;

  // lane to tile index
  always_comb begin
    sel = '0;
    for (int i = 0; i < mc_pkg::num_tiles; i++) begin
      if (rep_v_i[i]) begin
        sel = mc_pkg::tile_id_t'(i);
      end
    end
  end

  // strobe and running count
  always_ff @(posedge clk) begin
    if (!reset) begin
      resp_v_o     <= 1'b0;
      resp_count_o <= '0;
    end else begin
      resp_v_o <= any_v;
      if (any_v) begin
        resp_count_o <= resp_count_o + mc_pkg::count_t'(1);
      end
    end
  end

  // tagged payload
  always_ff @(posedge clk) begin
    if (any_v) begin
      resp_tile_o <= sel;
      resp_data_o <= rep_data_i[sel];
    end
  end

endmodule

/* hw/mc_dispatch.sv */
// command dispatcher that registers host commands and strobes the addressed tile
`timescale 1ns/10ps

module mc_dispatch (
  input  logic                         clk,
  input  logic                         reset,

  // host command
  input  logic                         cmd_v_i,
  input  mc_pkg::op_e                  cmd_op_i,
  input  mc_pkg::coord_t               cmd_coord_i,
  input  mc_pkg::addr_t                cmd_addr_i,
  input  mc_pkg::data_t                cmd_data_i,

  // to the tiles
  output logic [mc_pkg::num_tiles-1:0] tile_v_o,
  output mc_pkg::op_e                  op_o,
  output mc_pkg::addr_t                addr_o,
  output mc_pkg::data_t                data_o,

  // bad coordinate
  output logic                         err_o
);

  logic                         in_range;
  logic [mc_pkg::num_tiles-1:0] tile_v_n;
  logic                         err_n;
  logic                         err_q;

  // coordinates at or past the tile count lead nowhere
  assign in_range = cmd_coord_i < mc_pkg::coord_t'(mc_pkg::num_tiles);

  // one-hot decode, at most one lane set
  always_comb begin
    for (int i = 0; i < mc_pkg::num_tiles; i++) begin
      tile_v_n[i] = cmd_v_i && (cmd_coord_i == mc_pkg::coord_t'(i));
    end
  end

  assign err_n = cmd_v_i && !in_range;

  // strobes
  // error pulse delayed one edge to line up with the tile replies
  always_ff @(posedge clk) begin
    if (!reset) begin
      tile_v_o <= '0;
      err_q    <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      tile_v_o <= tile_v_n;
      err_q    <= err_n;
      err_o    <= err_q;
    end
  end

  // shared command bus to all tiles
  always_ff @(posedge clk) begin
    if (cmd_v_i) begin
      op_o   <= cmd_op_i;
      addr_o <= cmd_addr_i;
      data_o <= cmd_data_i;
    end
  end

endmodule

/* hw/mc_pkg.sv */
// shared widths, tile count, memory depth, vector typedefs and the opcode enum
package mc_pkg;

  // fabric size
  localparam int num_tiles = 4;
  localparam int mem_words = 16;

  // field widths
  localparam int data_w    = 32;
  localparam int addr_w    = $clog2(mem_words);
  localparam int coord_w   = 3;
  localparam int tile_id_w = $clog2(num_tiles);
  localparam int count_w   = 16;

  // one data word
  typedef logic [data_w-1:0] data_t;

  // word address inside one tile
  typedef logic [addr_w-1:0] addr_t;

  // host tile coordinate, wider than the tile index so that
  // coordinates past the last tile can be named and caught
  typedef logic [coord_w-1:0] coord_t;

  // tile tag on replies
  typedef logic [tile_id_w-1:0] tile_id_t;

  // reply counter, wraps
  typedef logic [count_w-1:0] count_t;

  // tile operations
  typedef enum logic [1:0] {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_add   = 2'd2
  } op_e;

endpackage

/* hw/mc_tile.sv */
// single tile: word memory executing write, read and atomic add with reply
`timescale 1ns/10ps

module mc_tile (
  input  logic          clk,
  input  logic          reset,

  // command from the dispatcher
  input  logic          v_i,
  input  mc_pkg::op_e   op_i,
  input  mc_pkg::addr_t addr_i,
  input  mc_pkg::data_t data_i,

  // reply pulse to the collector
  output logic          rep_v_o,
  output mc_pkg::data_t rep_data_o
);

  mc_pkg::data_t mem [mc_pkg::mem_words];

  mc_pkg::data_t old_word;
  mc_pkg::data_t new_word;
  logic          wr_en;
  logic          rep_en;

  // current contents of the addressed word
  assign old_word = mem[addr_i];

  // opcode decode
  always_comb begin
    new_word = old_word;
    wr_en    = 1'b0;
    rep_en   = 1'b0;
    case (op_i)
      mc_pkg::op_write: begin
        new_word = data_i;
        wr_en    = v_i;
      end
      mc_pkg::op_read: begin
        rep_en = v_i;
      end
      mc_pkg::op_add: begin
        // old word goes back, sum stays behind
        new_word = old_word + data_i;
        wr_en    = v_i;
        rep_en   = v_i;
      end
      default: begin
        wr_en  = 1'b0;
        rep_en = 1'b0;
      end
    endcase
  end

  // memory, written on the same edge the old word is captured,
  // so a following command already sees the update
  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < mc_pkg::mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[addr_i] <= new_word;
    end
  end

  // reply strobe
  always_ff @(posedge clk) begin
    if (!reset) begin
      rep_v_o <= 1'b0;
    end else begin
      rep_v_o <= rep_en;
    end
  end

  // reply word
  always_ff @(posedge clk) begin
    if (rep_en) begin
      rep_data_o <= old_word;
    end
  end

endmodule

/* hw/mc_top.sv */
// fabric top: dispatcher, tile array and reply collector
`timescale 1ns/10ps

module mc_top (
  input  logic             clk,
  input  logic             reset,

  // host commands
  input  logic             cmd_v_i,
  input  mc_pkg::op_e      cmd_op_i,
  input  mc_pkg::coord_t   cmd_coord_i,
  input  mc_pkg::addr_t    cmd_addr_i,
  input  mc_pkg::data_t    cmd_data_i,

  // tagged replies
  output logic             resp_v_o,
  output mc_pkg::tile_id_t resp_tile_o,
  output mc_pkg::data_t    resp_data_o,
  output mc_pkg::count_t   resp_count_o,

  // bad coordinate
  output logic             err_o
);

  logic [mc_pkg::num_tiles-1:0]          tile_v;
  mc_pkg::op_e                           tile_op;
  mc_pkg::addr_t                         tile_addr;
  mc_pkg::data_t                         tile_data;

  logic [mc_pkg::num_tiles-1:0]          rep_v;
  mc_pkg::data_t [mc_pkg::num_tiles-1:0] rep_data;

  mc_dispatch u_dispatch (
    .clk         (clk),
    .reset       (reset),
    .cmd_v_i     (cmd_v_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_coord_i (cmd_coord_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .tile_v_o    (tile_v),
    .op_o        (tile_op),
    .addr_o      (tile_addr),
    .data_o      (tile_data),
    .err_o       (err_o)
  );

  // tile array on a shared command bus
  for (genvar i = 0; i < mc_pkg::num_tiles; i++) begin : g_tile
    mc_tile u_tile (
      .clk        (clk),
      .reset      (reset),
      .v_i        (tile_v[i]),
      .op_i       (tile_op),
      .addr_i     (tile_addr),
      .data_i     (tile_data),
      .rep_v_o    (rep_v[i]),
      .rep_data_o (rep_data[i])
    );
  end

  mc_collect u_collect (
    .clk          (clk),
    .reset        (reset),
    .rep_v_i      (rep_v),
    .rep_data_i   (rep_data),
    .resp_v_o     (resp_v_o),
    .resp_tile_o  (resp_tile_o),
    .resp_data_o  (resp_data_o),
    .resp_count_o (resp_count_o)
  );

endmodule

/* list.f */
hw/mc_pkg.sv
hw/mc_dispatch.sv
hw/mc_tile.sv
hw/mc_collect.sv
hw/mc_top.sv
verif/mc_chk.sv
verif/mc_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module mc_tb \
  -f list.f \
  -o mc_sim

./obj_dir/mc_sim 2>&1 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi

/* verif/mc_chk.sv */
// bound assertions on mc_top for strobe exclusivity, one-hot tile strobe, error timing and reset
`timescale 1ns/10ps

module mc_chk (
  input logic                         clk,
  input logic                         reset,
  input logic                         cmd_v_i,
  input mc_pkg::coord_t               cmd_coord_i,
  input logic [mc_pkg::num_tiles-1:0] tile_v_i,
  input logic [mc_pkg::num_tiles-1:0] rep_v_i,
  input logic                         err_i,
  input logic                         resp_v_i
);

  logic bad_coord;

  // host command that names a missing tile
  assign bad_coord = cmd_v_i && (cmd_coord_i >= mc_pkg::coord_t'(mc_pkg::num_tiles));

  // error pulse takes the slot a tile reply would have had
  err_rep_excl: assert property (@(posedge clk) disable iff (!reset)
    !(err_i && (|rep_v_i)))
    else $error("err_o and a tile reply pulse high in the same cycle");

  tile_onehot: assert property (@(posedge clk) disable iff (!reset)
    $onehot0(tile_v_i))
    else $error("more than one tile strobe set");

  err_after_bad: assert property (@(posedge clk) disable iff (!reset)
    bad_coord |-> ##2 err_i)
    else $error("no err_o pulse one edge after a bad coordinate");

  // and only then
  err_only_bad: assert property (@(posedge clk) disable iff (!reset)
    !bad_coord |-> ##2 !err_i)
    else $error("err_o pulse without a bad coordinate");

  resp_in_reset: assert property (@(posedge clk)
    !reset |=> !resp_v_i)
    else $error("resp_v_o high during reset");

endmodule

bind mc_top mc_chk u_chk (
  .clk         (clk),
  .reset       (reset),
  .cmd_v_i     (cmd_v_i),
  .cmd_coord_i (cmd_coord_i),
  .tile_v_i    (tile_v),
  .rep_v_i     (rep_v),
  .err_i       (err_o),
  .resp_v_i    (resp_v_o)
);

/* verif/mc_tb.sv */
// testbench for mc_top: clock, reset, xorshift stimulus, reference model and checks
`timescale 1ns/10ps

module mc_tb;

  localparam int num_cmds    = 2000;
  localparam int drain_limit = 20;

  logic             clk;
  logic             reset;

  logic             cmd_v;
  mc_pkg::op_e      cmd_op;
  mc_pkg::coord_t   cmd_coord;
  mc_pkg::addr_t    cmd_addr;
  mc_pkg::data_t    cmd_data;

  logic             resp_v;
  mc_pkg::tile_id_t resp_tile;
  mc_pkg::data_t    resp_data;
  mc_pkg::count_t   resp_count;
  logic             err;

  // reference memory, one row per tile
  mc_pkg::data_t    model_mem [mc_pkg::num_tiles][mc_pkg::mem_words];

  // expected replies in command order, with the edge they are due after
  int               exp_due [$];
  mc_pkg::tile_id_t exp_tile [$];
  mc_pkg::data_t    exp_data [$];
  int               err_due [$];

  mc_pkg::count_t   reply_total;
  mc_pkg::count_t   seen_count;
  logic             exp_resp;
  logic             exp_err;
  logic             mon_en;
  int               edge_cnt;
  int               wait_cycles;

  logic [31:0]      rng_state;
  logic [1:0]       last_tile;
  mc_pkg::addr_t    last_addr;

  mc_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .cmd_v_i      (cmd_v),
    .cmd_op_i     (cmd_op),
    .cmd_coord_i  (cmd_coord),
    .cmd_addr_i   (cmd_addr),
    .cmd_data_i   (cmd_data),
    .resp_v_o     (resp_v),
    .resp_tile_o  (resp_tile),
    .resp_data_o  (resp_data),
    .resp_count_o (resp_count),
    .err_o        (err)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // drive one cycle of host input and update the model
  task automatic issue(input logic v, input mc_pkg::op_e op, input mc_pkg::coord_t coord,
                       input mc_pkg::addr_t addr, input mc_pkg::data_t data);
    int            t;
    int            a;
    mc_pkg::data_t old;
    @(posedge clk);
    #2;
    cmd_v     = v;
    cmd_op    = op;
    cmd_coord = coord;
    cmd_addr  = addr;
    cmd_data  = data;
    if (v) begin
      if (coord >= mc_pkg::coord_t'(mc_pkg::num_tiles)) begin
        // sampled at the next edge, pulse after the one after
        err_due.push_back(edge_cnt + 2);
      end else begin
        t   = int'(coord);
        a   = int'(addr);
        old = model_mem[t][a];
        if (op == mc_pkg::op_write) begin
          model_mem[t][a] = data;
        end else begin
          exp_due.push_back(edge_cnt + 3);
          exp_tile.push_back(coord[1:0]);
          exp_data.push_back(old);
          reply_total = reply_total + 16'd1;
          if (op == mc_pkg::op_add) begin
            model_mem[t][a] = old + data;
          end
        end
      end
    end
  endtask

  task automatic read_all();
    for (int t = 0; t < mc_pkg::num_tiles; t++) begin
      for (int a = 0; a < mc_pkg::mem_words; a++) begin
        issue(1'b1, mc_pkg::op_read, mc_pkg::coord_t'(t), mc_pkg::addr_t'(a), 32'h0);
      end
    end
  endtask

  task automatic directed_cmds();
    // adds back to back across the 32-bit wrap
    issue(1'b1, mc_pkg::op_write, 3'd2, 4'd5, 32'hffff_fffe);
    repeat (4) begin
      issue(1'b1, mc_pkg::op_add, 3'd2, 4'd5, 32'h1);
    end
    issue(1'b1, mc_pkg::op_read, 3'd2, 4'd5, 32'h0);
    // coordinate 5 must not alias onto tile 1
    issue(1'b1, mc_pkg::op_write, 3'd5, 4'd5, 32'hdead_beef);
    issue(1'b1, mc_pkg::op_read, 3'd1, 4'd5, 32'h0);
    issue(1'b0, mc_pkg::op_read, 3'd0, 4'd0, 32'h0);
  endtask

  task automatic random_command();
    logic [31:0] r;
    logic [31:0] d;
    int          pick;
    mc_pkg::op_e op;
    rng_state = xorshift32(rng_state);
    r         = rng_state;
    rng_state = xorshift32(rng_state);
    d         = rng_state;
    pick      = int'(r[7:0]) % 10;
    if (r[9:8] == 2'd0) begin
      op = mc_pkg::op_write;
    end else if (r[9:8] == 2'd1) begin
      op = mc_pkg::op_read;
    end else begin
      op = mc_pkg::op_add;
    end
    // keep the same word now and then for back-to-back hits
    if (r[14:12] >= 3'd3) begin
      last_tile = r[11:10];
      last_addr = r[19:16];
    end
    if (pick < 2) begin
      issue(1'b0, op, {1'b0, last_tile}, last_addr, d);
    end else if (pick == 2) begin
      issue(1'b1, op, {1'b1, r[11:10]}, r[19:16], d);
    end else begin
      issue(1'b1, op, {1'b0, last_tile}, last_addr, d);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (mon_en) begin
      exp_resp = (exp_due.size() != 0) && (exp_due[0] == edge_cnt);
      exp_err  = (err_due.size() != 0) && (err_due[0] == edge_cnt);
      check_value("resp_v_o", 32'(resp_v), 32'(exp_resp));
      check_value("err_o", 32'(err), 32'(exp_err));
      if (exp_resp) begin
        check_value("resp_tile_o", 32'(resp_tile), 32'(exp_tile[0]));
        check_value("resp_data_o", resp_data, exp_data[0]);
        void'(exp_due.pop_front());
        void'(exp_tile.pop_front());
        void'(exp_data.pop_front());
        seen_count = seen_count + 16'd1;
      end
      if (exp_err) begin
        void'(err_due.pop_front());
      end
      check_value("resp_count_o", 32'(resp_count), 32'(seen_count));
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b0;
    cmd_v       = 1'b0;
    cmd_op      = mc_pkg::op_write;
    cmd_coord   = '0;
    cmd_addr    = '0;
    cmd_data    = '0;
    mon_en      = 1'b0;
    edge_cnt    = 0;
    reply_total = '0;
    seen_count  = '0;
    rng_state   = 32'd23;
    last_tile   = 2'd0;
    last_addr   = '0;
    for (int t = 0; t < mc_pkg::num_tiles; t++) begin
      for (int a = 0; a < mc_pkg::mem_words; a++) begin
        model_mem[t][a] = '0;
      end
    end

    repeat (3) @(posedge clk);
    #2;
    reset  = 1'b1;
    mon_en = 1'b1;

    read_all();
    directed_cmds();
    for (int n = 0; n < num_cmds; n++) begin
      random_command();
    end
    read_all();
    issue(1'b0, mc_pkg::op_read, 3'd0, 4'd0, 32'h0);

    wait_cycles = 0;
    while ((exp_due.size() != 0 || err_due.size() != 0) && wait_cycles < drain_limit) begin
      @(posedge clk);
      wait_cycles++;
    end
    #2;
    if (exp_due.size() != 0 || err_due.size() != 0) begin
      $display("timeout: %0d replies and %0d error pulses never arrived",
               exp_due.size(), err_due.size());
      stop_on_failure();
    end else begin
      check_value("resp_count_o", 32'(resp_count), 32'(reply_total));
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule
